//--- src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ########################################
    // Widths.
    // ########################################
    localparam int data_width = 32;
    localparam int w_oper     = 3;
    localparam int w_func     = 5;
    localparam int md_cycles  = 32;   // One quotient or product bit per step.

    // ########################################
    // Oper codes.
    // ########################################
    localparam logic [w_oper-1:0] oper_alus = 3'd0;
    localparam logic [w_oper-1:0] oper_aluu = 3'd1;
    localparam logic [w_oper-1:0] oper_mfhi = 3'd2;
    localparam logic [w_oper-1:0] oper_mflo = 3'd3;
    localparam logic [w_oper-1:0] oper_mthi = 3'd4;
    localparam logic [w_oper-1:0] oper_mtlo = 3'd5;
    localparam logic [w_oper-1:0] oper_mfc0 = 3'd6;

    // ########################################
    // Func codes.
    // ########################################
    localparam logic [w_func-1:0] func_none = 5'd0;
    localparam logic [w_func-1:0] func_and  = 5'd1;
    localparam logic [w_func-1:0] func_or   = 5'd2;
    localparam logic [w_func-1:0] func_xor  = 5'd3;
    localparam logic [w_func-1:0] func_nor  = 5'd4;
    localparam logic [w_func-1:0] func_lui  = 5'd5;
    localparam logic [w_func-1:0] func_sll  = 5'd6;
    localparam logic [w_func-1:0] func_srl  = 5'd7;
    localparam logic [w_func-1:0] func_sra  = 5'd8;
    localparam logic [w_func-1:0] func_add  = 5'd9;
    localparam logic [w_func-1:0] func_sub  = 5'd10;
    localparam logic [w_func-1:0] func_slt  = 5'd11;
    localparam logic [w_func-1:0] func_mul  = 5'd12;
    localparam logic [w_func-1:0] func_div  = 5'd13;

    // Coprocessor 0 register numbers.
    localparam logic [4:0] cp0_badvaddr = 5'd8;
    localparam logic [4:0] cp0_count    = 5'd9;
    localparam logic [4:0] cp0_compare  = 5'd11;
    localparam logic [4:0] cp0_status   = 5'd12;
    localparam logic [4:0] cp0_cause    = 5'd13;
    localparam logic [4:0] cp0_epc      = 5'd14;

endpackage

`default_nettype wire

//--- src/sglalu.sv
`timescale 1ns/1ps
`default_nettype none

module sglalu import cpu_pkg::*; (
    input  logic [w_oper-1:0]     oper,
    input  logic [w_func-1:0]     func,
    input  logic [data_width-1:0] cp0_rt_data,
    output logic [data_width-1:0] cp0_rd_data,
    input  logic [data_width-1:0] source_a,
    input  logic [data_width-1:0] source_b,
    output logic [data_width-1:0] result,
    output logic                  mulalu_sign,
    output logic [w_func-1:0]     mulalu_func,
    input  logic [data_width-1:0] hi,
    output logic                  hi_write,
    output logic [data_width-1:0] hi_write_data,
    input  logic [data_width-1:0] lo,
    output logic                  lo_write,
    output logic [data_width-1:0] lo_write_data,
    output logic                  ov
);

    logic [data_width-1:0] add_result;
    logic [data_width-1:0] sub_result;
    logic [4:0]            shamt;
    logic                  less;
    logic                  add_ovf;
    logic                  sub_ovf;
    logic                  is_md;

    assign add_result = source_a + source_b;
    assign sub_result = source_a - source_b;
    assign shamt      = source_b[4:0];   // Only the low five bits count.

    // Signed compare under oper_alus, unsigned under anything else.
    assign less = (oper == oper_alus) ? ($signed(source_a) < $signed(source_b)) :
                                        (source_a < source_b);

    // Operands of equal sign whose result flips sign.
    assign add_ovf = (source_a[data_width-1] == source_b[data_width-1]) &&
                     (add_result[data_width-1] != source_a[data_width-1]);
    assign sub_ovf = (source_a[data_width-1] != source_b[data_width-1]) &&
                     (sub_result[data_width-1] != source_a[data_width-1]);

    assign ov = (oper == oper_alus) &&
                (((func == func_add) && add_ovf) || ((func == func_sub) && sub_ovf));

    assign cp0_rd_data = source_b;

    // ########################################
    // Multiply/divide and HI/LO requests.
    // ########################################
    assign is_md       = (func == func_mul) || (func == func_div);
    assign mulalu_func = is_md ? func : func_none;
    assign mulalu_sign = is_md && (oper != oper_aluu);

    assign hi_write      = (oper == oper_mthi);
    assign hi_write_data = source_a;
    assign lo_write      = (oper == oper_mtlo);
    assign lo_write_data = source_a;

    // ########################################
    // Result select.
    // ########################################
    always_comb begin
        case (func)
            func_and: begin
                // Moves from HI, LO and CP0 ride on the AND slot.
                case (oper)
                    oper_mfhi: result = hi;
                    oper_mflo: result = lo;
                    oper_mfc0: result = cp0_rt_data;
                    default:   result = source_a & source_b;
                endcase
            end
            func_or:  result = source_a | source_b;
            func_xor: result = source_a ^ source_b;
            func_nor: result = ~(source_a | source_b);
            func_lui: result = {source_b[15:0], 16'h0000};
            func_sll: result = source_a << shamt;
            func_srl: result = source_a >> shamt;
            func_sra: result = $signed(source_a) >>> shamt;   // Sign fill.
            func_add: result = add_result;
            func_sub: result = sub_result;
            func_slt: result = {{(data_width-1){1'b0}}, less};
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/mulalu.sv
`timescale 1ns/1ps
`default_nettype none

module mulalu import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [w_func-1:0]     mulalu_func,
    input  logic                  mulalu_sign,
    input  logic [data_width-1:0] source_a,
    input  logic [data_width-1:0] source_b,
    output logic                  busy,
    output logic                  done,
    output logic [data_width-1:0] md_hi,
    output logic [data_width-1:0] md_lo
);

    logic                         start;
    logic                         a_neg;
    logic                         b_neg;
    logic [data_width-1:0]        a_mag;
    logic [data_width-1:0]        b_mag_in;
    logic [$clog2(md_cycles)-1:0] step;

    // Operation state loaded at start.
    logic                  is_div;
    logic                  neg_q;
    logic                  neg_r;
    logic [data_width-1:0] b_mag;
    logic [data_width-1:0] acc_hi;
    logic [data_width-1:0] acc_lo;

    logic [data_width:0]     mul_sum;
    logic [data_width:0]     div_shift;
    logic [data_width+1:0]   div_diff;
    logic [2*data_width-1:0] prod;

    assign start = (mulalu_func != func_none) && !busy;

    assign a_neg    = mulalu_sign & source_a[data_width-1];
    assign b_neg    = mulalu_sign & source_b[data_width-1];
    assign a_mag    = a_neg ? -source_a : source_a;
    assign b_mag_in = b_neg ? -source_b : source_b;

    // ########################################
    // Step datapath.
    // ########################################
    // Each multiply step adds the multiplicand into the upper half when the low bit is set.
    assign mul_sum = {1'b0, acc_hi} + (acc_lo[0] ? {1'b0, b_mag} : '0);

    // The extra bit keeps the restoring borrow exact.
    assign div_shift = {acc_hi, acc_lo[data_width-1]};
    assign div_diff  = {1'b0, div_shift} - {2'b00, b_mag};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (int'(step) == md_cycles - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;   // Results valid while done is high.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_div <= (mulalu_func == func_div);
            neg_q  <= a_neg ^ b_neg;
            neg_r  <= a_neg;   // Remainder follows the dividend.
            b_mag  <= b_mag_in;
            acc_hi <= '0;
            acc_lo <= a_mag;
        end else if (busy) begin
            if (is_div) begin
                if (div_diff[data_width+1]) begin
                    acc_hi <= div_shift[data_width-1:0];   // Restore.
                end else begin
                    acc_hi <= div_diff[data_width-1:0];
                end
                acc_lo <= {acc_lo[data_width-2:0], ~div_diff[data_width+1]};
            end else begin
                acc_hi <= mul_sum[data_width:1];
                acc_lo <= {mul_sum[0], acc_lo[data_width-1:1]};
            end
        end
    end

    // ########################################
    // Sign correction.
    // ########################################
    assign prod = {acc_hi, acc_lo};

    always_comb begin
        if (is_div) begin
            md_lo = neg_q ? -acc_lo : acc_lo;
            md_hi = neg_r ? -acc_hi : acc_hi;
        end else begin
            {md_hi, md_lo} = neg_q ? -prod : prod;   // Full 64-bit negate.
        end
    end

endmodule

`default_nettype wire

//--- src/hilo_regs.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_regs import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hi_write,
    input  logic [data_width-1:0] hi_write_data,
    input  logic                  lo_write,
    input  logic [data_width-1:0] lo_write_data,
    input  logic                  done,
    input  logic [data_width-1:0] md_hi,
    input  logic [data_width-1:0] md_lo,
    output logic [data_width-1:0] hi,
    output logic [data_width-1:0] lo
);

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (done) begin
            // Completion takes both halves and wins over a move.
            hi <= md_hi;
            lo <= md_lo;
        end else begin
            if (hi_write) begin
                hi <= hi_write_data;
            end
            if (lo_write) begin
                lo <= lo_write_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0_regs import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cp0_write,
    input  logic [4:0]            cp0_addr,
    input  logic [data_width-1:0] cp0_rd_data,
    output logic [data_width-1:0] cp0_rt_data,
    output logic                  timer_irq
);

    logic [data_width-1:0] count;
    logic [data_width-1:0] compare;
    logic [data_width-1:0] status;
    logic [data_width-1:0] cause;
    logic [data_width-1:0] epc;
    logic                  half_tick;
    logic                  match;

    assign match     = (count == compare) && (compare != '0);
    assign timer_irq = cause[15];   // Timer interrupt pending bit.

    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= '0;
            compare   <= '0;
            status    <= '0;
            cause     <= '0;
            epc       <= '0;
            half_tick <= 1'b0;
        end else begin
            half_tick <= ~half_tick;
            if (cp0_write && cp0_addr == cp0_count) begin
                count <= cp0_rd_data;
            end else if (half_tick) begin
                count <= count + 1'b1;   // Half clock rate.
            end
            if (cp0_write && cp0_addr == cp0_status) begin
                status <= cp0_rd_data;
            end
            if (cp0_write && cp0_addr == cp0_epc) begin
                epc <= cp0_rd_data;
            end
            if (cp0_write && cp0_addr == cp0_compare) begin
                compare   <= cp0_rd_data;
                cause[15] <= 1'b0;   // Acknowledge.
            end else if (match) begin
                cause[15] <= 1'b1;
            end
        end
    end

    // Read port.
    always_comb begin
        case (cp0_addr)
            cp0_count:    cp0_rt_data = count;
            cp0_compare:  cp0_rt_data = compare;
            cp0_status:   cp0_rt_data = status;
            cp0_cause:    cp0_rt_data = cause;
            cp0_epc:      cp0_rt_data = epc;
            default:      cp0_rt_data = '0;   // Badvaddr reads as zero too.
        endcase
    end

endmodule

`default_nettype wire

//--- src/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [w_oper-1:0]     oper,
    input  logic [w_func-1:0]     func,
    input  logic [data_width-1:0] source_a,
    input  logic [data_width-1:0] source_b,
    input  logic [4:0]            cp0_addr,
    input  logic                  cp0_write,
    output logic [data_width-1:0] result,
    output logic                  ov,
    output logic                  busy,
    output logic                  timer_irq
);

    // ########################################
    // Internal nets.
    // ########################################
    logic [data_width-1:0] cp0_rt_data;
    logic [data_width-1:0] cp0_rd_data;
    logic [w_func-1:0]     mulalu_func;
    logic                  mulalu_sign;
    logic [data_width-1:0] hi;
    logic [data_width-1:0] lo;
    logic                  hi_write;
    logic [data_width-1:0] hi_write_data;
    logic                  lo_write;
    logic [data_width-1:0] lo_write_data;
    logic                  done;
    logic [data_width-1:0] md_hi;
    logic [data_width-1:0] md_lo;

    sglalu u_sglalu (
        .oper          (oper),
        .func          (func),
        .cp0_rt_data   (cp0_rt_data),
        .cp0_rd_data   (cp0_rd_data),
        .source_a      (source_a),
        .source_b      (source_b),
        .result        (result),
        .mulalu_sign   (mulalu_sign),
        .mulalu_func   (mulalu_func),
        .hi            (hi),
        .hi_write      (hi_write),
        .hi_write_data (hi_write_data),
        .lo            (lo),
        .lo_write      (lo_write),
        .lo_write_data (lo_write_data),
        .ov            (ov)
    );

    // Multi-cycle multiply and divide.
    mulalu u_mulalu (
        .clk         (clk),
        .reset       (reset),
        .mulalu_func (mulalu_func),
        .mulalu_sign (mulalu_sign),
        .source_a    (source_a),
        .source_b    (source_b),
        .busy        (busy),
        .done        (done),
        .md_hi       (md_hi),
        .md_lo       (md_lo)
    );

    hilo_regs u_hilo_regs (
        .clk           (clk),
        .reset         (reset),
        .hi_write      (hi_write),
        .hi_write_data (hi_write_data),
        .lo_write      (lo_write),
        .lo_write_data (lo_write_data),
        .done          (done),
        .md_hi         (md_hi),
        .md_lo         (md_lo),
        .hi            (hi),
        .lo            (lo)
    );

    cp0_regs u_cp0_regs (
        .clk         (clk),
        .reset       (reset),
        .cp0_write   (cp0_write),
        .cp0_addr    (cp0_addr),
        .cp0_rd_data (cp0_rd_data),
        .cp0_rt_data (cp0_rt_data),
        .timer_irq   (timer_irq)
    );

endmodule

`default_nettype wire

//--- verification/exec_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage_tb import cpu_pkg::*; ;

    localparam int clk_period  = 8;
    localparam int test_ops    = 400;   // Rough count of operations over all tests.
    localparam int op_cycles   = 40;
    localparam int timeout_ns  = (test_ops * op_cycles + 500) * clk_period;
    localparam int timer_delta = 10;

    logic                  clk;
    logic                  reset;
    logic [w_oper-1:0]     oper;
    logic [w_func-1:0]     func;
    logic [data_width-1:0] source_a;
    logic [data_width-1:0] source_b;
    logic [4:0]            cp0_addr;
    logic                  cp0_write;
    logic [data_width-1:0] result;
    logic                  ov;
    logic                  busy;
    logic                  timer_irq;

    int          errors    = 0;
    logic [31:0] rng_state = 32'hd974_b3b9;
    logic [w_func-1:0] sc_funcs [11] = '{func_and, func_or, func_xor, func_nor, func_lui,
        func_sll, func_srl, func_sra, func_add, func_sub, func_slt};

    exec_stage u_dut (
        .clk       (clk),
        .reset     (reset),
        .oper      (oper),
        .func      (func),
        .source_a  (source_a),
        .source_b  (source_b),
        .cp0_addr  (cp0_addr),
        .cp0_write (cp0_write),
        .result    (result),
        .ov        (ov),
        .busy      (busy),
        .timer_irq (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ########################################
    // Models and helpers.
    // ########################################
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] model_result(logic [2:0] op, logic [4:0] fn,
                                                 logic [31:0] a, logic [31:0] b);
        longint diff;
        case (fn)
            func_and: return a & b;
            func_or:  return a | b;
            func_xor: return a ^ b;
            func_nor: return ~(a | b);
            func_lui: return b << 16;
            func_sll: return a << b[4:0];
            func_srl: return a >> b[4:0];
            func_sra: return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            func_add: return a + b;
            func_sub: return a - b;
            func_slt: begin
                if (op == oper_alus) diff = longint'($signed(a)) - longint'($signed(b));
                else diff = longint'({32'h0, a}) - longint'({32'h0, b});
                return (diff < 0) ? 32'h1 : 32'h0;
            end
            default:  return 32'h0;
        endcase
    endfunction

    function automatic logic model_ov(logic [2:0] op, logic [4:0] fn,
                                      logic [31:0] a, logic [31:0] b);
        longint s;
        if (op != oper_alus) return 1'b0;
        if (fn == func_add) s = longint'($signed(a)) + longint'($signed(b));
        else if (fn == func_sub) s = longint'($signed(a)) - longint'($signed(b));
        else return 1'b0;
        return s[63:31] != {33{s[31]}};   // Does not fit in 32 signed bits.
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERR %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic apply_and_check(input logic [2:0] op, input logic [4:0] fn,
                                   input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        oper     <= op;
        func     <= fn;
        source_a <= a;
        source_b <= b;
        @(negedge clk);
        check_value("result", result, model_result(op, fn, a, b));
        check_value("ov", {31'h0, ov}, {31'h0, model_ov(op, fn, a, b)});
    endtask

    task automatic read_cp0(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk);
        cp0_write <= 1'b0;
        oper      <= oper_mfc0;
        func      <= func_and;
        cp0_addr  <= addr;
        @(negedge clk);
        data = result;
    endtask

    task automatic write_cp0(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        cp0_write <= 1'b1;
        cp0_addr  <= addr;
        source_b  <= data;
        oper      <= oper_alus;
        func      <= func_none;
        @(posedge clk);
        cp0_write <= 1'b0;
    endtask

    // ########################################
    // Tests.
    // ########################################
    task automatic single_cycle_test(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = next_random();
            apply_and_check(r[31] ? oper_aluu : oper_alus, sc_funcs[r % 11],
                            next_random(), next_random());
        end
    endtask

    task automatic overflow_test();
        apply_and_check(oper_alus, func_add, 32'h7fff_ffff, 32'h1);
        apply_and_check(oper_alus, func_sub, 32'h8000_0000, 32'h1);
        apply_and_check(oper_alus, func_add, 32'h8000_0000, 32'h8000_0000);
        apply_and_check(oper_alus, func_sub, 32'h0, 32'h8000_0000);
        apply_and_check(oper_alus, func_add, 32'hffff_ffff, 32'h1);
        apply_and_check(oper_aluu, func_add, 32'h7fff_ffff, 32'h1);
        apply_and_check(oper_aluu, func_sub, 32'h8000_0000, 32'h1);
        apply_and_check(oper_alus, func_slt, 32'h7fff_ffff, 32'hffff_ffff);
    endtask

    task automatic hilo_move_test(input int count);
        logic [31:0] h;
        logic [31:0] l;
        for (int i = 0; i < count; i++) begin
            h = next_random();
            l = next_random();
            @(posedge clk);
            oper     <= oper_mthi;
            func     <= func_none;
            source_a <= h;
            @(posedge clk);
            oper     <= oper_mtlo;
            source_a <= l;
            @(posedge clk);
            oper <= oper_mfhi;
            func <= func_and;
            @(negedge clk);
            check_value("result (mfhi)", result, h);
            @(posedge clk);
            oper <= oper_mflo;
            @(negedge clk);
            check_value("result (mflo)", result, l);
        end
    endtask

    task automatic run_muldiv(input logic [2:0] op, input logic [4:0] fn,
                              input logic [31:0] a, input logic [31:0] b);
        logic [63:0] prod;
        logic [31:0] exp_hi;
        logic [31:0] exp_lo;
        longint      sa;
        longint      sb;
        int          cycles;
        sa = $signed(a);
        sb = $signed(b);
        if (fn == func_mul) begin
            prod   = (op == oper_aluu) ? ({32'h0, a} * {32'h0, b}) : sa * sb;
            exp_hi = prod[63:32];
            exp_lo = prod[31:0];
        end else if (b == 32'h0) begin
            exp_lo = (op != oper_aluu && a[31]) ? 32'h1 : 32'hffff_ffff;
            exp_hi = a;
        end else if (op == oper_aluu) begin
            exp_lo = a / b;
            exp_hi = a % b;
        end else begin
            exp_lo = 32'(sa / sb);
            exp_hi = 32'(sa % sb);
        end
        @(posedge clk);
        oper     <= op;
        func     <= fn;
        source_a <= a;
        source_b <= b;
        @(posedge clk);
        source_a <= next_random();   // A second start with other operands.
        source_b <= next_random();
        @(negedge clk);
        cycles = 0;
        while (busy === 1'b1 && cycles < md_cycles + 8) begin
            cycles++;
            @(posedge clk);
            if (cycles == 3) func <= func_none;
            @(negedge clk);
        end
        assert (cycles == md_cycles) else begin
            errors++;
            $display("busy stayed high for %0d cycles instead of %0d", cycles, md_cycles);
        end
        @(posedge clk);
        oper <= oper_mfhi;
        func <= func_and;
        @(negedge clk);
        check_value("result (hi)", result, exp_hi);
        @(posedge clk);
        oper <= oper_mflo;
        @(negedge clk);
        check_value("result (lo)", result, exp_lo);
    endtask

    task automatic muldiv_test(input int count);
        logic [31:0] r;
        run_muldiv(oper_alus, func_mul, 32'hffff_fffd, 32'h0000_0007);
        run_muldiv(oper_aluu, func_mul, 32'hffff_ffff, 32'hffff_ffff);
        run_muldiv(oper_alus, func_div, 32'hffff_ff9c, 32'h0000_0007);
        run_muldiv(oper_alus, func_div, 32'h8000_0000, 32'hffff_ffff);
        run_muldiv(oper_alus, func_div, 32'hffff_f000, 32'h0);   // Divide by zero.
        run_muldiv(oper_aluu, func_div, 32'h1234_5678, 32'h0);
        for (int i = 0; i < count; i++) begin
            r = next_random();
            run_muldiv(r[0] ? oper_aluu : oper_alus, r[1] ? func_div : func_mul,
                       next_random(), next_random() >> r[6:2]);
        end
    endtask

    task automatic cp0_test();
        logic [31:0] v;
        logic [31:0] c1;
        logic [31:0] c2;
        v = next_random();
        write_cp0(cp0_status, v);
        read_cp0(cp0_status, c1);
        check_value("status", c1, v);
        v = next_random();
        write_cp0(cp0_epc, v);
        read_cp0(cp0_epc, c1);
        check_value("epc", c1, v);
        write_cp0(cp0_cause, 32'hffff_ffff);
        read_cp0(cp0_cause, c1);
        check_value("cause", c1, 32'h0);
        write_cp0(5'd3, 32'hffff_ffff);
        read_cp0(5'd3, c1);
        check_value("cp0 reg 3", c1, 32'h0);
        read_cp0(cp0_count, c1);
        repeat (9) @(posedge clk);
        read_cp0(cp0_count, c2);
        check_value("count delta", c2 - c1, 32'd5);   // Ten clocks at half rate.
    endtask

    task automatic timer_test();
        logic [31:0] c;
        int          cycles;
        check_value("timer_irq", {31'h0, timer_irq}, 32'h0);
        read_cp0(cp0_count, c);
        write_cp0(cp0_compare, c + timer_delta);
        cycles = 0;
        while (timer_irq !== 1'b1 && cycles < 2 * timer_delta + 2) begin
            @(negedge clk);
            cycles++;
        end
        assert (timer_irq === 1'b1) else begin
            errors++;
            $display("timer_irq did not rise within %0d cycles", 2 * timer_delta + 2);
        end
        write_cp0(cp0_compare, 32'h0);
        @(negedge clk);
        check_value("timer_irq", {31'h0, timer_irq}, 32'h0);
    endtask

    // ########################################
    // Main sequence and watchdog.
    // ########################################
    initial begin
        reset     = 1'b1;
        oper      = oper_alus;
        func      = func_none;
        source_a  = '0;
        source_b  = '0;
        cp0_addr  = '0;
        cp0_write = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        single_cycle_test(200);
        overflow_test();
        hilo_move_test(8);
        muldiv_test(16);
        cp0_test();
        timer_test();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/cpu_pkg.sv
src/sglalu.sv
src/mulalu.sv
src/hilo_regs.sv
src/cp0_regs.sv
src/exec_stage.sv
verification/exec_stage_tb.sv
